// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_periph
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hdl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/apb_front.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module apb_front (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  logic [`SOC_ADDR_W-1:0] paddr_i,
   input  logic [`SOC_DATA_W-1:0] pwdata_i,
   input  logic [`SOC_STRB_W-1:0] pstrb_i,
   output logic [`SOC_DATA_W-1:0] prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output soc_bus_pkg::bus_req_t  req_o,
   input  soc_bus_pkg::bus_rsp_t  rsp_i
);
   logic                   busy;
   logic                   capture;
   logic                   req_vld;
   logic                   req_wr;
   logic [`SOC_OFF_W-1:0]  req_off;
   logic [`SOC_DATA_W-1:0] req_wdata;
   logic [`SOC_STRB_W-1:0] req_wstrb;

   // first cycle of the access phase only
   assign capture = psel_i & penable_i & ~busy;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy      <= 1'b0;
         req_vld   <= 1'b0;
         pready_o  <= 1'b0;
         pslverr_o <= 1'b0;
      end else begin
         req_vld   <= capture;
         pready_o  <= rsp_i.valid;
         pslverr_o <= rsp_i.valid & rsp_i.err;
         if (capture) begin
            busy <= 1'b1;
         end else if (pready_o) begin
            busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (capture) begin
         req_wr    <= pwrite_i;
         req_off   <= paddr_i[`SOC_ADDR_W-1:2];
         req_wdata <= pwdata_i;
         req_wstrb <= pstrb_i;
      end
      // held for the pready cycle
      if (rsp_i.valid) begin
         prdata_o <= rsp_i.rdata;
      end
   end

   always_comb begin
      req_o.valid  = req_vld;
      req_o.write  = req_wr;
      req_o.offset = req_off;
      req_o.wdata  = req_wdata;
      req_o.wstrb  = req_wstrb;
   end

   a_penable_needs_psel: assert property (
      @(posedge clk_i) disable iff (rst_i) penable_i |-> psel_i
   );

endmodule

// File: hdl/int_mem.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module int_mem #(
   parameter int DEPTH = `SOC_MEM_DEPTH
) (
   input  logic                  clk_i,
   input  soc_bus_pkg::bus_req_t req_i,
   output soc_bus_pkg::bus_rsp_t rsp_o
);
   localparam int AW = $clog2(DEPTH);

   logic [`SOC_DATA_W-1:0] mem [DEPTH];
   logic [AW-1:0]          idx;

   // higher offset bits alias for small depths
   assign idx = req_i.offset[AW-1:0];

   always_ff @(posedge clk_i) begin
      if (req_i.valid && req_i.write) begin
         for (int b = 0; b < `SOC_STRB_W; b++) begin
            if (req_i.wstrb[b]) begin
               mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   // answered in the request cycle
   always_comb begin
      rsp_o.valid = req_i.valid;
      rsp_o.err   = 1'b0;
      rsp_o.rdata = '0;
      if (req_i.valid && !req_i.write) begin
         rsp_o.rdata = mem[idx];
      end
   end

endmodule

// File: hdl/pbus_split.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module pbus_split (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  soc_bus_pkg::bus_req_t req_i,
   output soc_bus_pkg::bus_req_t mem_req_o,
   output soc_bus_pkg::bus_req_t timer_req_o,
   output soc_bus_pkg::bus_req_t uart_req_o,
   input  soc_bus_pkg::bus_rsp_t mem_rsp_i,
   input  soc_bus_pkg::bus_rsp_t timer_rsp_i,
   input  soc_bus_pkg::bus_rsp_t uart_rsp_i,
   output soc_bus_pkg::bus_rsp_t rsp_o
);
   // select bits as seen in the word offset
   localparam int SEL_HI = `SOC_SEL_HI - 2;
   localparam int SEL_LO = `SOC_SEL_LO - 2;

   soc_bus_pkg::target_e  tgt;
   soc_bus_pkg::bus_req_t fwd_q;
   logic                  mem_vld_q;
   logic                  tmr_vld_q;
   logic                  uart_vld_q;
   logic                  none_vld_q;

   assign tgt = soc_bus_pkg::target_e'(req_i.offset[SEL_HI:SEL_LO]);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         mem_vld_q  <= 1'b0;
         tmr_vld_q  <= 1'b0;
         uart_vld_q <= 1'b0;
         none_vld_q <= 1'b0;
      end else begin
         mem_vld_q  <= req_i.valid & (tgt == soc_bus_pkg::TGT_MEM);
         tmr_vld_q  <= req_i.valid & (tgt == soc_bus_pkg::TGT_TIMER);
         uart_vld_q <= req_i.valid & (tgt == soc_bus_pkg::TGT_UART);
         none_vld_q <= req_i.valid & (tgt == soc_bus_pkg::TGT_NONE);
      end
   end

   // targets see a region-relative offset
   always_ff @(posedge clk_i) begin
      if (req_i.valid) begin
         fwd_q                      <= req_i;
         fwd_q.offset[SEL_HI:SEL_LO] <= '0;
      end
   end

   always_comb begin
      mem_req_o         = fwd_q;
      mem_req_o.valid   = mem_vld_q;
      timer_req_o       = fwd_q;
      timer_req_o.valid = tmr_vld_q;
      uart_req_o        = fwd_q;
      uart_req_o.valid  = uart_vld_q;
   end

   // idle targets drive zeros so unmapped reads return 0
   always_comb begin
      rsp_o.valid = mem_rsp_i.valid | timer_rsp_i.valid | uart_rsp_i.valid | none_vld_q;
      rsp_o.rdata = mem_rsp_i.rdata | timer_rsp_i.rdata | uart_rsp_i.rdata;
      rsp_o.err   = mem_rsp_i.err | timer_rsp_i.err | uart_rsp_i.err | none_vld_q;
   end

   a_one_target: assert property (
      @(posedge clk_i) disable iff (rst_i)
         $onehot0({mem_req_o.valid, timer_req_o.valid, uart_req_o.valid})
   );

endmodule

// File: hdl/soc_bus_pkg.sv
`include "soc_config.svh"

package soc_bus_pkg;

   // region picked by the select bits
   typedef enum logic [1:0] {
      TGT_MEM   = 2'd0,
      TGT_TIMER = 2'd1,
      TGT_UART  = 2'd2,
      TGT_NONE  = 2'd3
   } target_e;

   // word offset with the region bits on top
   typedef struct packed {
      logic                   valid;
      logic                   write;
      logic [`SOC_OFF_W-1:0]  offset;
      logic [`SOC_DATA_W-1:0] wdata;
      logic [`SOC_STRB_W-1:0] wstrb;
   } bus_req_t;

   // valid for one cycle per request
   typedef struct packed {
      logic                   valid;
      logic [`SOC_DATA_W-1:0] rdata;
      logic                   err;
   } bus_rsp_t;

endpackage

// File: hdl/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus widths
`define SOC_DATA_W 32
`define SOC_STRB_W (`SOC_DATA_W/8)

// APB byte address and the word offset without its two low bits
`define SOC_ADDR_W 12
`define SOC_OFF_W (`SOC_ADDR_W-2)

// byte address bits that pick a target
`define SOC_SEL_HI 11
`define SOC_SEL_LO 10

// internal memory words
`define SOC_MEM_DEPTH 256

// bit period in clock cycles after reset
`define SOC_UART_DIV_RESET 4

`endif

// File: hdl/soc_periph_pkg.sv
package soc_periph_pkg;

   // timer word offsets
   typedef enum logic [7:0] {
      TMR_CTRL  = 8'd0,
      TMR_COUNT = 8'd1
   } timer_reg_e;

   // uart word offsets
   typedef enum logic [7:0] {
      UART_DIV    = 8'd0,
      UART_TXDATA = 8'd1,
      UART_STATUS = 8'd2
   } uart_reg_e;

   // transmitter FSM
   typedef enum logic [1:0] {
      UART_IDLE,
      UART_START,
      UART_DATA,
      UART_STOP
   } uart_state_e;

endpackage

// File: hdl/soc_periph_top.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module soc_periph_top (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  logic [`SOC_ADDR_W-1:0] paddr_i,
   input  logic [`SOC_DATA_W-1:0] pwdata_i,
   input  logic [`SOC_STRB_W-1:0] pstrb_i,
   output logic [`SOC_DATA_W-1:0] prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output logic                   txd_o
);
   soc_bus_pkg::bus_req_t front_req;
   soc_bus_pkg::bus_rsp_t front_rsp;
   soc_bus_pkg::bus_req_t mem_req;
   soc_bus_pkg::bus_rsp_t mem_rsp;
   soc_bus_pkg::bus_req_t timer_req;
   soc_bus_pkg::bus_rsp_t timer_rsp;
   soc_bus_pkg::bus_req_t uart_req;
   soc_bus_pkg::bus_rsp_t uart_rsp;

   apb_front u_apb_front (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .psel_i   (psel_i),
      .penable_i(penable_i),
      .pwrite_i (pwrite_i),
      .paddr_i  (paddr_i),
      .pwdata_i (pwdata_i),
      .pstrb_i  (pstrb_i),
      .prdata_o (prdata_o),
      .pready_o (pready_o),
      .pslverr_o(pslverr_o),
      .req_o    (front_req),
      .rsp_i    (front_rsp)
   );

   pbus_split u_pbus_split (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (front_req),
      .mem_req_o  (mem_req),
      .timer_req_o(timer_req),
      .uart_req_o (uart_req),
      .mem_rsp_i  (mem_rsp),
      .timer_rsp_i(timer_rsp),
      .uart_rsp_i (uart_rsp),
      .rsp_o      (front_rsp)
   );

   int_mem #(
      .DEPTH(`SOC_MEM_DEPTH)
   ) u_int_mem (
      .clk_i(clk_i),
      .req_i(mem_req),
      .rsp_o(mem_rsp)
   );

   timer_csrs u_timer (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .req_i(timer_req),
      .rsp_o(timer_rsp)
   );

   uart_tx u_uart_tx (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .req_i(uart_req),
      .rsp_o(uart_rsp),
      .txd_o(txd_o)
   );

endmodule

// File: hdl/timer_csrs.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module timer_csrs (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  soc_bus_pkg::bus_req_t req_i,
   output soc_bus_pkg::bus_rsp_t rsp_o
);
   localparam int RW = $bits(soc_periph_pkg::timer_reg_e);
   localparam int DW = `SOC_DATA_W;

   soc_periph_pkg::timer_reg_e reg_sel;
   logic                       ctrl_we;
   logic                       enable;
   logic [DW-1:0]              count;

   assign reg_sel = soc_periph_pkg::timer_reg_e'(req_i.offset[RW-1:0]);
   assign ctrl_we = req_i.valid & req_i.write & (reg_sel == soc_periph_pkg::TMR_CTRL);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         enable <= 1'b0;
         count  <= '0;
      end else begin
         if (ctrl_we) begin
            enable <= req_i.wdata[0];
         end
         // clear wins over the increment
         if (ctrl_we && req_i.wdata[1]) begin
            count <= '0;
         end else if (enable) begin
            count <= count + 1'b1;
         end
      end
   end

   always_comb begin
      rsp_o.valid = req_i.valid;
      rsp_o.rdata = '0;
      rsp_o.err   = 1'b0;
      if (req_i.valid) begin
         case (reg_sel)
            soc_periph_pkg::TMR_CTRL: begin
               // clear bit reads back as 0
               if (!req_i.write) begin
                  rsp_o.rdata = DW'(enable);
               end
            end
            soc_periph_pkg::TMR_COUNT: begin
               if (req_i.write) begin
                  rsp_o.err = 1'b1;
               end else begin
                  rsp_o.rdata = count;
               end
            end
            default: rsp_o.err = 1'b1;
         endcase
      end
   end

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module uart_tx (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  soc_bus_pkg::bus_req_t req_i,
   output soc_bus_pkg::bus_rsp_t rsp_o,
   output logic                  txd_o
);
   localparam int RW    = $bits(soc_periph_pkg::uart_reg_e);
   localparam int DW    = `SOC_DATA_W;
   localparam int DIV_W = 16;

   soc_periph_pkg::uart_reg_e   reg_sel;
   soc_periph_pkg::uart_state_e state;
   logic [DIV_W-1:0]            div;
   logic [DIV_W-1:0]            baud_cnt;
   logic [2:0]                  bit_cnt;
   logic [7:0]                  shift;
   logic                        tick;
   logic                        busy;
   logic                        div_we;
   logic                        tx_start;

   assign reg_sel = soc_periph_pkg::uart_reg_e'(req_i.offset[RW-1:0]);
   assign tick    = (baud_cnt == '0);
   assign busy    = (state != soc_periph_pkg::UART_IDLE);

   always_comb begin
      rsp_o.valid = req_i.valid;
      rsp_o.rdata = '0;
      rsp_o.err   = 1'b0;
      div_we      = 1'b0;
      tx_start    = 1'b0;
      if (req_i.valid) begin
         case (reg_sel)
            soc_periph_pkg::UART_DIV: begin
               if (req_i.write) begin
                  div_we = 1'b1;
               end else begin
                  rsp_o.rdata = DW'(div);
               end
            end
            soc_periph_pkg::UART_TXDATA: begin
               // byte dropped while a frame is out
               if (req_i.write) begin
                  rsp_o.err = busy;
                  tx_start  = ~busy;
               end
            end
            soc_periph_pkg::UART_STATUS: begin
               if (req_i.write) begin
                  rsp_o.err = 1'b1;
               end else begin
                  rsp_o.rdata = DW'(busy);
               end
            end
            default: rsp_o.err = 1'b1;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state    <= soc_periph_pkg::UART_IDLE;
         txd_o    <= 1'b1;
         div      <= DIV_W'(`SOC_UART_DIV_RESET);
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         if (div_we) begin
            div <= (req_i.wdata[DIV_W-1:0] == '0) ? DIV_W'(1) : req_i.wdata[DIV_W-1:0];
         end
         if (state != soc_periph_pkg::UART_IDLE) begin
            baud_cnt <= tick ? div - 1'b1 : baud_cnt - 1'b1;
         end
         case (state)
            soc_periph_pkg::UART_IDLE: begin
               if (tx_start) begin
                  state    <= soc_periph_pkg::UART_START;
                  txd_o    <= 1'b0;
                  baud_cnt <= div - 1'b1;
               end
            end
            soc_periph_pkg::UART_START: begin
               if (tick) begin
                  state   <= soc_periph_pkg::UART_DATA;
                  txd_o   <= shift[0];
                  bit_cnt <= '0;
               end
            end
            soc_periph_pkg::UART_DATA: begin
               if (tick) begin
                  if (bit_cnt == 3'd7) begin
                     state <= soc_periph_pkg::UART_STOP;
                     txd_o <= 1'b1;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                     txd_o   <= shift[1];
                  end
               end
            end
            default: begin
               if (tick) begin
                  state <= soc_periph_pkg::UART_IDLE;
               end
            end
         endcase
      end
   end

   // lsb first
   always_ff @(posedge clk_i) begin
      if (tx_start) begin
         shift <= req_i.wdata[7:0];
      end else if (state == soc_periph_pkg::UART_DATA && tick) begin
         shift <= shift >> 1;
      end
   end

   a_idle_line_high: assert property (
      @(posedge clk_i) disable iff (rst_i) (state == soc_periph_pkg::UART_IDLE) |-> txd_o
   );

endmodule

// File: src.f
+incdir+hdl
hdl/soc_bus_pkg.sv
hdl/soc_periph_pkg.sv
hdl/apb_front.sv
hdl/pbus_split.sv
hdl/int_mem.sv
hdl/timer_csrs.sv
hdl/uart_tx.sv
hdl/soc_periph_top.sv
testbench/tb_soc_periph.sv

// File: testbench/tb_soc_periph.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module tb_soc_periph;

   localparam int CLK_HALF    = 5;
   localparam int RESET_CYC   = 5;
   localparam int MAX_WAIT    = 20;
   localparam int UART_DIV_TB = 8;
   // rough budget of transfers, idle gaps and one UART frame
   localparam int NUM_XFERS   = 64;
   localparam int XFER_CYC    = 6;
   localparam int IDLE_CYC    = 60;
   localparam int FRAME_CYC   = 10 * UART_DIV_TB;
   localparam int MARGIN_CYC  = 500;
   localparam int TIMEOUT_NS  = 2 * CLK_HALF *
      (RESET_CYC + NUM_XFERS * XFER_CYC + IDLE_CYC + FRAME_CYC + MARGIN_CYC);

   localparam logic [`SOC_ADDR_W-1:0] TMR_BASE   = `SOC_ADDR_W'(1 << `SOC_SEL_LO);
   localparam logic [`SOC_ADDR_W-1:0] UART_BASE  = `SOC_ADDR_W'(2 << `SOC_SEL_LO);
   localparam logic [`SOC_ADDR_W-1:0] NONE_BASE  = `SOC_ADDR_W'(3 << `SOC_SEL_LO);
   localparam logic [`SOC_ADDR_W-1:0] TMR_CTRL_A = TMR_BASE;
   localparam logic [`SOC_ADDR_W-1:0] TMR_CNT_A  = TMR_BASE + 12'd4;
   localparam logic [`SOC_ADDR_W-1:0] UART_DIV_A = UART_BASE;
   localparam logic [`SOC_ADDR_W-1:0] UART_TX_A  = UART_BASE + 12'd4;
   localparam logic [`SOC_ADDR_W-1:0] UART_ST_A  = UART_BASE + 12'd8;

   logic                   clk_i = 1'b0;
   logic                   rst_i = 1'b1;
   logic                   psel_i = 1'b0;
   logic                   penable_i = 1'b0;
   logic                   pwrite_i = 1'b0;
   logic [`SOC_ADDR_W-1:0] paddr_i = '0;
   logic [`SOC_DATA_W-1:0] pwdata_i = '0;
   logic [`SOC_STRB_W-1:0] pstrb_i = '0;
   logic [`SOC_DATA_W-1:0] prdata_o;
   logic                   pready_o;
   logic                   pslverr_o;
   logic                   txd_o;

   int          errors = 0;
   int          checks = 0;
   logic [31:0] rng_state = 32'd20;
   logic [31:0] mem_model [256];

   soc_periph_top UUT (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .psel_i   (psel_i),
      .penable_i(penable_i),
      .pwrite_i (pwrite_i),
      .paddr_i  (paddr_i),
      .pwdata_i (pwdata_i),
      .pstrb_i  (pstrb_i),
      .prdata_o (prdata_o),
      .pready_o (pready_o),
      .pslverr_o(pslverr_o),
      .txd_o    (txd_o)
   );

   always #CLK_HALF clk_i = ~clk_i;

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] expected, input string msg);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, expected);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk_i);
   endtask

   // one APB transfer with pready expected 3 cycles after penable
   task automatic apb_xfer(input logic wr, input logic [`SOC_ADDR_W-1:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb,
                           output logic [31:0] rdata, output logic err);
      int cycles;
      cycles = 0;
      @(negedge clk_i);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = wr;
      paddr_i   = addr;
      pwdata_i  = wdata;
      pstrb_i   = strb;
      @(negedge clk_i);
      penable_i = 1'b1;
      do begin
         @(negedge clk_i);
         cycles++;
      end while (!pready_o && cycles < MAX_WAIT);
      if (!pready_o) begin
         errors++;
         $display("pready_o did not rise within %0d cycles for address %h", MAX_WAIT, addr);
      end else begin
         check(32'(cycles), 32'd3, "pready_o latency after penable_i");
      end
      rdata     = prdata_o;
      err       = pslverr_o;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      pstrb_i   = '0;
   endtask

   task automatic apb_write(input logic [`SOC_ADDR_W-1:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic err);
      logic [31:0] unused_rdata;
      apb_xfer(1'b1, addr, wdata, strb, unused_rdata, err);
   endtask

   task automatic apb_read(input logic [`SOC_ADDR_W-1:0] addr, output logic [31:0] rdata,
                           output logic err);
      apb_xfer(1'b0, addr, 32'h0, 4'h0, rdata, err);
   endtask

   // samples txd_o near the middle of each bit
   task automatic uart_receive(input int div, output logic [7:0] data,
                               output logic start_bit, output logic stop_bit);
      @(negedge txd_o);
      repeat (div / 2) @(negedge clk_i);
      start_bit = txd_o;
      for (int i = 0; i < 8; i++) begin
         repeat (div) @(negedge clk_i);
         data[i] = txd_o;
      end
      repeat (div) @(negedge clk_i);
      stop_bit = txd_o;
   endtask

   task automatic mem_round_trip();
      logic [31:0] rdata;
      logic [31:0] wdata;
      logic        err;
      logic [7:0]  idx;
      logic [7:0]  addrs [$];
      for (int i = 0; i < 16; i++) begin
         rdata = next_random();
         idx   = rdata[7:0];
         wdata = next_random();
         apb_write({2'b00, idx, 2'b00}, wdata, 4'hf, err);
         check(32'(err), 32'd0, "memory write error");
         mem_model[idx] = wdata;
         addrs.push_back(idx);
      end
      foreach (addrs[i]) begin
         apb_read({2'b00, addrs[i], 2'b00}, rdata, err);
         check(32'(err), 32'd0, "memory read error");
         check(rdata, mem_model[addrs[i]], "memory read data");
      end
   endtask

   task automatic byte_strobe_merge();
      logic [31:0] rdata;
      logic        err;
      apb_write(12'h0a8, 32'h11223344, 4'hf, err);
      apb_write(12'h0a8, 32'haabbccdd, 4'h4, err);
      check(32'(err), 32'd0, "partial strobe write error");
      apb_read(12'h0a8, rdata, err);
      check(rdata, 32'h11bb3344, "merged byte lanes");
   endtask

   task automatic timer_count_rules();
      logic [31:0] c1;
      logic [31:0] c2;
      logic        err;
      apb_read(TMR_CNT_A, c1, err);
      check(c1, 32'd0, "timer count after reset");
      apb_write(TMR_CTRL_A, 32'h1, 4'hf, err);
      apb_read(TMR_CNT_A, c1, err);
      idle_cycles(10);
      apb_read(TMR_CNT_A, c2, err);
      check(32'(c2 > c1), 32'd1, "timer count increasing while enabled");
      apb_write(TMR_CTRL_A, 32'h0, 4'hf, err);
      apb_read(TMR_CNT_A, c1, err);
      idle_cycles(10);
      apb_read(TMR_CNT_A, c2, err);
      check(c2, c1, "timer count frozen while disabled");
      apb_write(TMR_CTRL_A, 32'h2, 4'hf, err);
      apb_read(TMR_CNT_A, c1, err);
      check(c1, 32'd0, "timer count after clear");
      apb_read(TMR_CTRL_A, c1, err);
      check(c1, 32'd0, "timer ctrl after clear");
      apb_write(TMR_CNT_A, 32'h5, 4'hf, err);
      check(32'(err), 32'd1, "write to read-only count");
   endtask

   task automatic uart_frame();
      logic [31:0] rdata;
      logic        err;
      logic [7:0]  tx_byte;
      logic [7:0]  rx_byte;
      logic        start_bit;
      logic        stop_bit;
      rdata   = next_random();
      tx_byte = rdata[7:0];
      apb_write(UART_DIV_A, 32'(UART_DIV_TB), 4'hf, err);
      check(32'(err), 32'd0, "uart divisor write error");
      apb_read(UART_DIV_A, rdata, err);
      check(rdata, 32'(UART_DIV_TB), "uart divisor read back");
      fork
         uart_receive(UART_DIV_TB, rx_byte, start_bit, stop_bit);
         begin
            apb_write(UART_TX_A, {24'h0, tx_byte}, 4'h1, err);
            check(32'(err), 32'd0, "uart txdata write error");
            apb_read(UART_ST_A, rdata, err);
            check(rdata, 32'd1, "uart status busy during frame");
            apb_write(UART_TX_A, {24'h0, ~tx_byte}, 4'h1, err);
            check(32'(err), 32'd1, "uart txdata write while busy");
         end
      join
      check(32'(start_bit), 32'd0, "uart start bit");
      check(32'(rx_byte), 32'(tx_byte), "uart data bits");
      check(32'(stop_bit), 32'd1, "uart stop bit");
      idle_cycles(UART_DIV_TB);
      apb_read(UART_ST_A, rdata, err);
      check(rdata, 32'd0, "uart status idle after frame");
   endtask

   task automatic unmapped_region();
      logic [31:0] rdata;
      logic        err;
      apb_read(NONE_BASE, rdata, err);
      check(32'(err), 32'd1, "unmapped read error");
      check(rdata, 32'd0, "unmapped read data");
      apb_write(NONE_BASE + 12'h10, 32'hdeadbeef, 4'hf, err);
      check(32'(err), 32'd1, "unmapped write error");
      apb_read(12'hffc, rdata, err);
      check(32'(err), 32'd1, "unmapped read error at top");
      check(rdata, 32'd0, "unmapped read data at top");
      apb_write(12'h3fc, 32'h5a5aa5a5, 4'hf, err);
      check(32'(err), 32'd0, "memory write after unmapped");
      apb_read(12'h3fc, rdata, err);
      check(rdata, 32'h5a5aa5a5, "memory read after unmapped");
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      repeat (RESET_CYC) @(negedge clk_i);
      rst_i = 1'b0;
      mem_round_trip();
      byte_strobe_merge();
      timer_count_rules();
      uart_frame();
      unmapped_region();
      idle_cycles(2);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
